// ==== all.f ====
verilog/isa_pkg.sv
verilog/mem_pkg.sv
verilog/instr_if.sv
verilog/store_if.sv
verilog/fetch_unit.sv
verilog/exec_unit.sv
verilog/store_unit.sv
verilog/mini_core.sv
tests/clk_gen.sv
tests/mini_core_asserts.sv
tests/mini_core_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module mini_core_tb -f all.f -o mini_core_sim

./obj_dir/mini_core_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
    exit 0
else
    exit 1
fi

// ==== tests/clk_gen.sv ====
`timescale 1ns/1ps

module clk_gen (
    output logic clk,
    output logic rst
);

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (10) @(posedge clk);
        #2 rst = 1'b0;
    end

endmodule

// ==== tests/mini_core_asserts.sv ====
`timescale 1ns/1ps

module mini_core_asserts #(
    parameter int DRAM_CREDITS = 2
) (
    input logic clk,
    input logic rst,
    input logic i_req_valid,
    input logic ebreak,
    input logic io_valid,
    input logic dram_req_valid,
    input logic dram_credit
);

    int outstanding;

    // DRAM requests not yet answered by a credit
    always_ff @(posedge clk) begin
        if (rst) begin
            outstanding <= 0;
        end else begin
            outstanding <= outstanding + int'(dram_req_valid) - int'(dram_credit);
        end
    end

    io_dram_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(io_valid && dram_req_valid))
        else $error("io_valid and dram_req_valid high together");

    no_fetch_after_halt: assert property (@(posedge clk) disable iff (rst)
        $past(ebreak) |-> !i_req_valid)
        else $error("instruction fetch issued after ebreak");

    dram_credit_limit: assert property (@(posedge clk) disable iff (rst)
        outstanding <= DRAM_CREDITS)
        else $error("more DRAM requests outstanding than credits");

endmodule

bind mini_core mini_core_asserts #(
    .DRAM_CREDITS (DRAM_CREDITS)
) asserts_i (
    .clk            (clk),
    .rst            (rst),
    .i_req_valid    (i_req_valid),
    .ebreak         (ebreak),
    .io_valid       (io_valid),
    .dram_req_valid (dram_req_valid),
    .dram_credit    (dram_credit)
);

// ==== tests/mini_core_tb.sv ====
`timescale 1ns/1ps

module mini_core_tb;
    import isa_pkg::*;
    import mem_pkg::*;

    localparam int DRAM_CREDITS   = 2;
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int MEM_WORDS      = 64;

    logic   clk;
    logic   gen_rst;
    logic   test_rst;
    logic   rst;
    logic   i_req_valid;
    addr_t  i_req_addr;
    logic   i_rsp_valid;
    instr_t i_rsp_data;
    logic   dram_req_valid;
    addr_t  dram_req_addr;
    word_t  dram_req_data;
    logic   dram_credit;
    logic   io_valid;
    word_t  io_data;
    logic   ebreak;

    instr_t prog [MEM_WORDS];
    int     prog_len;
    addr_t  exp_addr [$];
    word_t  exp_data [$];
    addr_t  act_addr [$];
    word_t  act_data [$];
    addr_t  req_q [$];
    int     req_due [$];
    int     credit_due [$];
    int     last_due;
    int     due;
    int     cycles;
    addr_t  fetch_exp;
    string  test_name;
    logic   hold_credits;
    logic   fail_shown;
    logic   done_ok;

    assign rst = gen_rst | test_rst;

    clk_gen clk_gen_i (
        .clk (clk),
        .rst (gen_rst)
    );

    mini_core #(
        .DRAM_CREDITS (DRAM_CREDITS)
    ) dut_i (
        .clk            (clk),
        .rst            (rst),
        .i_req_valid    (i_req_valid),
        .i_req_addr     (i_req_addr),
        .i_rsp_valid    (i_rsp_valid),
        .i_rsp_data     (i_rsp_data),
        .dram_req_valid (dram_req_valid),
        .dram_req_addr  (dram_req_addr),
        .dram_req_data  (dram_req_data),
        .dram_credit    (dram_credit),
        .io_valid       (io_valid),
        .io_data        (io_data),
        .ebreak         (ebreak)
    );

    function automatic instr_t enc(opcode_t op, reg_idx_t rd, reg_idx_t rs, imm_t imm);
        return {op, rd, rs, 4'h0, imm};
    endfunction

    task automatic stop_with_failure();
        fail_shown = 1'b1;
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_word(string name, word_t exp, word_t act);
        if (exp !== act) begin
            $display("ERR %s: expected %h, actual %h", name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_addr(string name, addr_t exp, addr_t act);
        if (exp !== act) begin
            $display("ERR %s: expected %h, actual %h", name, exp, act);
            stop_with_failure();
        end
    endtask

    // Unused words hold no-ops tagged with their own word index
    task automatic clear_program();
        for (int i = 0; i < MEM_WORDS; i++) begin
            prog[i] = {4'h0, 12'h0, 16'(i)};
        end
        prog_len = 0;
    endtask

    task automatic emit(instr_t w);
        prog[prog_len] = w;
        prog_len++;
    endtask

    // Builds 0xFFFFFF00 in rd from LI and ADD, using r15 as scratch
    task automatic emit_io_base(reg_idx_t rd);
        emit(enc(OP_LI, rd, 4'd0, 16'hff00));
        emit(enc(OP_LI, 4'd15, 4'd0, 16'hffff));
        for (int i = 0; i < 16; i++) begin
            emit(enc(OP_ADD, 4'd15, 4'd15, 16'h0));
        end
        emit(enc(OP_ADD, rd, 4'd15, 16'h0));
    endtask

    // Reference interpreter for the expected store stream
    task automatic run_reference();
        word_t    regs [NUM_REGS];
        instr_t   w;
        reg_idx_t rd;
        reg_idx_t rs;
        imm_t     imm;
        exp_addr.delete();
        exp_data.delete();
        for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] = '0;
        end
        for (int pc = 0; pc < MEM_WORDS; pc++) begin
            w   = prog[pc];
            rd  = w[RD_LSB +: 4];
            rs  = w[RS_LSB +: 4];
            imm = w[IMM_LSB +: 16];
            if (w[OPC_LSB +: 4] == OP_EBREAK) begin
                break;
            end else if (w[OPC_LSB +: 4] == OP_LI) begin
                regs[rd] = {16'h0, imm};
            end else if (w[OPC_LSB +: 4] == OP_ADD) begin
                regs[rd] = regs[rd] + regs[rs];
            end else if (w[OPC_LSB +: 4] == OP_ST) begin
                exp_addr.push_back(regs[rd] + {16'h0, imm});
                exp_data.push_back(regs[rs]);
            end
        end
    endtask

    task automatic reset_dut(string name);
        test_name = name;
        run_reference();
        @(posedge clk);
        #2 test_rst = 1'b1;
        repeat (10) @(posedge clk);
        act_addr.delete();
        act_data.delete();
        req_q.delete();
        req_due.delete();
        credit_due.delete();
        last_due  = 0;
        fetch_exp = '0;
        #2 test_rst = 1'b0;
    endtask

    task automatic wait_stores(int n);
        while (act_addr.size() < n) begin
            @(posedge clk);
        end
    endtask

    task automatic finish_program(string name);
        while (!(ebreak && act_addr.size() >= exp_addr.size())) begin
            @(posedge clk);
        end
        repeat (10) @(posedge clk);
        check_word({name, " store count"}, word_t'(exp_addr.size()), word_t'(act_addr.size()));
        for (int i = 0; i < exp_addr.size(); i++) begin
            check_addr($sformatf("%s addr %0d", name, i), exp_addr[i], act_addr[i]);
            check_word($sformatf("%s data %0d", name, i), exp_data[i], act_data[i]);
        end
    endtask

    // Monitors sample at the falling edge where everything is settled
    always @(negedge clk) begin
        if (!rst && i_req_valid) begin
            // Fetches run 0, 4, 8 and so on after each reset
            check_addr({test_name, " fetch addr"}, fetch_exp, i_req_addr);
            fetch_exp = fetch_exp + addr_t'(4);
            due = cycles + 1 + int'($urandom % 32'd4);
            if (due <= last_due) begin
                due = last_due + 1;
            end
            last_due = due;
            req_q.push_back(i_req_addr);
            req_due.push_back(due);
        end
        if (!rst && io_valid) begin
            act_addr.push_back(IO_BUS_ADDR);
            act_data.push_back(io_data);
        end
        if (!rst && dram_req_valid) begin
            if (dram_req_addr == IO_BUS_ADDR) begin
                $display("A store to the IO address was sent to DRAM");
                stop_with_failure();
            end
            act_addr.push_back(dram_req_addr);
            act_data.push_back(dram_req_data);
            credit_due.push_back(cycles + 1 + int'($urandom % 32'd5));
        end
    end

    // Instruction memory responses and DRAM credits
    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles without finishing the tests", cycles);
            stop_with_failure();
        end
        #2;
        i_rsp_valid = 1'b0;
        dram_credit = 1'b0;
        if (!rst && req_q.size() > 0 && req_due[0] <= cycles) begin
            i_rsp_valid = 1'b1;
            i_rsp_data  = prog[req_q[0][7:2]];
            void'(req_q.pop_front());
            void'(req_due.pop_front());
        end
        if (!rst && !hold_credits) begin
            for (int i = 0; i < credit_due.size(); i++) begin
                if (credit_due[i] <= cycles) begin
                    credit_due.delete(i);
                    dram_credit = 1'b1;
                    break;
                end
            end
        end
    end

    task automatic test_io_output();
        clear_program();
        emit(enc(OP_LI, 4'd3, 4'd0, 16'd5));
        emit(enc(OP_LI, 4'd4, 4'd0, 16'd7));
        emit_io_base(4'd1);
        emit(enc(OP_ST, 4'd1, 4'd3, 16'h0));
        emit(enc(OP_ADD, 4'd3, 4'd4, 16'h0));
        emit(enc(OP_ST, 4'd1, 4'd3, 16'h0));
        emit(enc(OP_ADD, 4'd3, 4'd3, 16'h0));
        emit(enc(OP_ST, 4'd1, 4'd3, 16'h0));
        emit(enc(OP_EBREAK, 4'd0, 4'd0, 16'h0));
        reset_dut("io_output");
        finish_program("io_output");
    endtask

    task automatic test_dram_stores();
        clear_program();
        emit(enc(OP_LI, 4'd1, 4'd0, 16'h0100));
        emit(enc(OP_LI, 4'd2, 4'd0, 16'h00ab));
        emit(enc(OP_ST, 4'd1, 4'd2, 16'h0000));
        emit(enc(OP_ST, 4'd1, 4'd2, 16'h0008));
        emit(enc(OP_LI, 4'd5, 4'd0, 16'h0055));
        emit(enc(OP_ADD, 4'd5, 4'd2, 16'h0));
        emit(enc(OP_ST, 4'd0, 4'd5, 16'h0040));
        emit(enc(OP_EBREAK, 4'd0, 4'd0, 16'h0));
        reset_dut("dram_stores");
        finish_program("dram_stores");
    endtask

    task automatic test_back_pressure();
        clear_program();
        emit(enc(OP_LI, 4'd1, 4'd0, 16'h0400));
        for (int i = 0; i < 6; i++) begin
            emit(enc(OP_LI, 4'd2, 4'd0, 16'(i + 16)));
            emit(enc(OP_ST, 4'd1, 4'd2, 16'(i * 4)));
        end
        emit(enc(OP_EBREAK, 4'd0, 4'd0, 16'h0));
        hold_credits = 1'b1;
        reset_dut("back_pressure");
        wait_stores(DRAM_CREDITS);
        repeat (40) @(posedge clk);
        check_word("back_pressure held", word_t'(DRAM_CREDITS), word_t'(act_addr.size()));
        hold_credits = 1'b0;
        finish_program("back_pressure");
    endtask

    task automatic test_io_ordering();
        clear_program();
        emit_io_base(4'd1);
        emit(enc(OP_LI, 4'd2, 4'd0, 16'h0800));
        emit(enc(OP_LI, 4'd3, 4'd0, 16'h0033));
        emit(enc(OP_ST, 4'd2, 4'd3, 16'h0000));
        emit(enc(OP_ST, 4'd2, 4'd3, 16'h0004));
        emit(enc(OP_ST, 4'd2, 4'd3, 16'h0008));
        emit(enc(OP_ST, 4'd1, 4'd3, 16'h0000));
        emit(enc(OP_ADD, 4'd3, 4'd3, 16'h0));
        emit(enc(OP_ST, 4'd2, 4'd3, 16'h000c));
        emit(enc(OP_ST, 4'd1, 4'd3, 16'h0000));
        emit(enc(OP_EBREAK, 4'd0, 4'd0, 16'h0));
        hold_credits = 1'b1;
        reset_dut("io_ordering");
        wait_stores(DRAM_CREDITS);
        repeat (30) @(posedge clk);
        // IO store must still wait behind the stalled third DRAM store
        check_word("io_ordering held", word_t'(DRAM_CREDITS), word_t'(act_addr.size()));
        hold_credits = 1'b0;
        finish_program("io_ordering");
    endtask

    task automatic test_halt();
        clear_program();
        emit(enc(OP_LI, 4'd1, 4'd0, 16'h0300));
        emit(enc(OP_LI, 4'd2, 4'd0, 16'h0011));
        emit(enc(OP_ST, 4'd1, 4'd2, 16'h0000));
        emit(enc(OP_EBREAK, 4'd0, 4'd0, 16'h0));
        emit(enc(OP_ST, 4'd1, 4'd2, 16'h0004));
        emit(enc(OP_LI, 4'd2, 4'd0, 16'h0099));
        emit(enc(OP_ST, 4'd1, 4'd2, 16'h0008));
        reset_dut("halt");
        finish_program("halt");
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            if (i_req_valid || !ebreak) begin
                $display("Fetch resumed or ebreak dropped after the core halted");
                stop_with_failure();
            end
        end
    endtask

    initial begin
        void'($urandom(84));
        test_rst     = 1'b0;
        i_rsp_valid  = 1'b0;
        i_rsp_data   = '0;
        dram_credit  = 1'b0;
        hold_credits = 1'b0;
        cycles       = 0;
        last_due     = 0;
        fetch_exp    = '0;
        test_name    = "";
        fail_shown   = 1'b0;
        done_ok      = 1'b0;
        wait (gen_rst == 1'b0);
        test_io_output();
        test_dram_stores();
        test_back_pressure();
        test_io_ordering();
        test_halt();
        done_ok = 1'b1;
        $display("ALL TESTS PASSED");
        $finish;
    end

    // Covers a run cut short by a failed assertion
    final begin
        if (!done_ok && !fail_shown) begin
            $display("SOME TESTS FAILED");
        end
    end

endmodule

// ==== verilog/exec_unit.sv ====
`timescale 1ns/1ps

module exec_unit #(
    parameter int INSTR_DEPTH = 4,
    parameter int STORE_DEPTH = 4
) (
    input  logic clk,
    input  logic rst,
    instr_if.dst instr,
    store_if.src store,
    output logic halt
);
    import isa_pkg::*;
    import mem_pkg::*;

    localparam int PTR_W  = (INSTR_DEPTH > 1) ? $clog2(INSTR_DEPTH) : 1;
    localparam int CNT_W  = $clog2(INSTR_DEPTH + 1);
    localparam int SCNT_W = $clog2(STORE_DEPTH + 1);

    typedef logic [PTR_W-1:0]  ptr_t;
    typedef logic [CNT_W-1:0]  count_t;
    typedef logic [SCNT_W-1:0] scredit_t;

    instr_t   queue [INSTR_DEPTH];
    ptr_t     wr_ptr;
    ptr_t     rd_ptr;
    count_t   count;
    word_t    regs [NUM_REGS];
    scredit_t store_credits;

    instr_t   head;
    opcode_t  opc;
    reg_idx_t rd;
    reg_idx_t rs;
    imm_t     imm;
    logic     st_stall;
    logic     push;
    logic     pop;

    function automatic ptr_t ptr_inc(ptr_t p);
        return (p == ptr_t'(INSTR_DEPTH - 1)) ? '0 : p + ptr_t'(1);
    endfunction

    // Decode of the queue head
    assign head = queue[rd_ptr];
    assign opc  = opcode_t'(head[OPC_LSB +: $bits(opcode_t)]);
    assign rd   = head[RD_LSB +: $bits(reg_idx_t)];
    assign rs   = head[RS_LSB +: $bits(reg_idx_t)];
    assign imm  = head[IMM_LSB +: $bits(imm_t)];

    // A store holds the head until the store queue has room
    assign st_stall = (opc == OP_ST) && (store_credits == '0);
    assign pop      = (count != '0) && !halt && !st_stall;
    assign push     = instr.valid && !halt;

    assign instr.credit = pop;

    // Store writes rs to address rd + imm
    assign store.valid = pop && (opc == OP_ST);
    assign store.addr  = regs[rd] + addr_t'(imm);
    assign store.data  = regs[rs];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (halt) begin
            // Drop everything fetched behind the EBREAK
            rd_ptr <= wr_ptr;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count <= count + count_t'(push) - count_t'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            queue[wr_ptr] <= instr.instr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            halt          <= 1'b0;
            store_credits <= scredit_t'(STORE_DEPTH);
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            store_credits <= store_credits - scredit_t'(store.valid)
                             + scredit_t'(store.credit);
            if (pop) begin
                case (opc)
                    OP_LI:     regs[rd] <= word_t'(imm);
                    OP_ADD:    regs[rd] <= regs[rd] + regs[rs];
                    OP_EBREAK: halt <= 1'b1;
                    // ST leaves through the store port, unknown opcodes do nothing
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

// ==== verilog/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit #(
    parameter int INSTR_DEPTH = 4
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            halt,

    output logic            i_req_valid,
    output mem_pkg::addr_t  i_req_addr,
    input  logic            i_rsp_valid,
    input  isa_pkg::instr_t i_rsp_data,

    instr_if.src            instr
);
    import mem_pkg::*;

    localparam int CNT_W = $clog2(INSTR_DEPTH + 1);

    typedef logic [CNT_W-1:0] credit_t;

    credit_t credit_cnt;
    addr_t   fetch_addr;
    logic    issue;

    // Space is reserved in the execute queue before the request goes out
    assign issue = (credit_cnt != '0) && !halt;

    always_ff @(posedge clk) begin
        if (rst) begin
            credit_cnt  <= credit_t'(INSTR_DEPTH);
            fetch_addr  <= '0;
            i_req_valid <= 1'b0;
        end else begin
            credit_cnt  <= credit_cnt - credit_t'(issue) + credit_t'(instr.credit);
            i_req_valid <= issue;
            if (issue) begin
                fetch_addr <= fetch_addr + addr_t'(4);
            end
        end
    end

    // Address of the request currently on the bus
    always_ff @(posedge clk) begin
        if (issue) begin
            i_req_addr <= fetch_addr;
        end
    end

    // Memory answers in order and never stalls, so responses go straight through
    assign instr.valid = i_rsp_valid;
    assign instr.instr = i_rsp_data;

endmodule

// ==== verilog/instr_if.sv ====
`timescale 1ns/1ps

interface instr_if;
    import isa_pkg::*;

    logic   valid;
    instr_t instr;
    // One pulse per instruction leaving the execute queue
    logic   credit;

    modport src (
        output valid,
        output instr,
        input  credit
    );

    modport dst (
        input  valid,
        input  instr,
        output credit
    );

endinterface

// ==== verilog/isa_pkg.sv ====
package isa_pkg;

    // Any other opcode value retires as a no-op
    typedef enum logic [3:0] {
        OP_LI     = 4'h1,
        OP_ADD    = 4'h2,
        OP_ST     = 4'h3,
        OP_EBREAK = 4'hf
    } opcode_t;

    typedef logic [3:0]  reg_idx_t;
    typedef logic [15:0] imm_t;
    typedef logic [31:0] instr_t;

    localparam int NUM_REGS = 16;

    // Instruction layout: opcode | rd | rs | unused | imm
    localparam int OPC_LSB = 28;
    localparam int RD_LSB  = 24;
    localparam int RS_LSB  = 20;
    localparam int IMM_LSB = 0;

endpackage

// ==== verilog/mem_pkg.sv ====
package mem_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;

    // Stores to this address go out on the IO port instead of DRAM
    localparam addr_t IO_BUS_ADDR = 32'hFFFF_FF00;

endpackage

// ==== verilog/mini_core.sv ====
`timescale 1ns/1ps

module mini_core #(
    parameter int INSTR_DEPTH  = 4,
    parameter int STORE_DEPTH  = 4,
    parameter int DRAM_CREDITS = 2
) (
    input  logic            clk,
    input  logic            rst,

    // Instruction memory
    output logic            i_req_valid,
    output mem_pkg::addr_t  i_req_addr,
    input  logic            i_rsp_valid,
    input  isa_pkg::instr_t i_rsp_data,

    // DRAM store requests
    output logic            dram_req_valid,
    output mem_pkg::addr_t  dram_req_addr,
    output mem_pkg::word_t  dram_req_data,
    input  logic            dram_credit,

    // IO bus
    output logic            io_valid,
    output mem_pkg::word_t  io_data,

    output logic            ebreak
);

    instr_if instr_ch ();
    store_if store_ch ();

    // ebreak also stops the fetch side
    fetch_unit #(
        .INSTR_DEPTH (INSTR_DEPTH)
    ) fetch_i (
        .clk         (clk),
        .rst         (rst),
        .halt        (ebreak),
        .i_req_valid (i_req_valid),
        .i_req_addr  (i_req_addr),
        .i_rsp_valid (i_rsp_valid),
        .i_rsp_data  (i_rsp_data),
        .instr       (instr_ch.src)
    );

    exec_unit #(
        .INSTR_DEPTH (INSTR_DEPTH),
        .STORE_DEPTH (STORE_DEPTH)
    ) exec_i (
        .clk   (clk),
        .rst   (rst),
        .instr (instr_ch.dst),
        .store (store_ch.src),
        .halt  (ebreak)
    );

    store_unit #(
        .STORE_DEPTH  (STORE_DEPTH),
        .DRAM_CREDITS (DRAM_CREDITS)
    ) store_i (
        .clk            (clk),
        .rst            (rst),
        .store          (store_ch.dst),
        .dram_req_valid (dram_req_valid),
        .dram_req_addr  (dram_req_addr),
        .dram_req_data  (dram_req_data),
        .dram_credit    (dram_credit),
        .io_valid       (io_valid),
        .io_data        (io_data)
    );

endmodule

// ==== verilog/store_if.sv ====
`timescale 1ns/1ps

interface store_if;
    import mem_pkg::*;

    logic  valid;
    addr_t addr;
    word_t data;
    // One pulse per store leaving the store queue
    logic  credit;

    modport src (
        output valid,
        output addr,
        output data,
        input  credit
    );

    modport dst (
        input  valid,
        input  addr,
        input  data,
        output credit
    );

endinterface

// ==== verilog/store_unit.sv ====
`timescale 1ns/1ps

module store_unit #(
    parameter int STORE_DEPTH  = 4,
    parameter int DRAM_CREDITS = 2
) (
    input  logic           clk,
    input  logic           rst,
    store_if.dst           store,

    output logic           dram_req_valid,
    output mem_pkg::addr_t dram_req_addr,
    output mem_pkg::word_t dram_req_data,
    input  logic           dram_credit,

    output logic           io_valid,
    output mem_pkg::word_t io_data
);
    import mem_pkg::*;

    localparam int PTR_W  = (STORE_DEPTH > 1) ? $clog2(STORE_DEPTH) : 1;
    localparam int CNT_W  = $clog2(STORE_DEPTH + 1);
    localparam int DCNT_W = $clog2(DRAM_CREDITS + 1);

    typedef logic [PTR_W-1:0]  ptr_t;
    typedef logic [CNT_W-1:0]  count_t;
    typedef logic [DCNT_W-1:0] dcredit_t;

    addr_t    q_addr [STORE_DEPTH];
    word_t    q_data [STORE_DEPTH];
    ptr_t     wr_ptr;
    ptr_t     rd_ptr;
    count_t   count;
    dcredit_t dram_credits;

    logic     head_io;
    logic     io_pop;
    logic     dram_pop;
    logic     pop;

    function automatic ptr_t ptr_inc(ptr_t p);
        return (p == ptr_t'(STORE_DEPTH - 1)) ? '0 : p + ptr_t'(1);
    endfunction

    // Stores leave strictly in order, an IO head waits behind a stalled DRAM store
    assign head_io  = (q_addr[rd_ptr] == IO_BUS_ADDR);
    assign io_pop   = (count != '0) && head_io;
    assign dram_pop = (count != '0) && !head_io && (dram_credits != '0);
    assign pop      = io_pop || dram_pop;

    assign store.credit = pop;

    assign io_valid       = io_pop;
    assign io_data        = q_data[rd_ptr];
    assign dram_req_valid = dram_pop;
    assign dram_req_addr  = q_addr[rd_ptr];
    assign dram_req_data  = q_data[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            count        <= '0;
            dram_credits <= dcredit_t'(DRAM_CREDITS);
        end else begin
            if (store.valid) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count        <= count + count_t'(store.valid) - count_t'(pop);
            dram_credits <= dram_credits - dcredit_t'(dram_pop) + dcredit_t'(dram_credit);
        end
    end

    always_ff @(posedge clk) begin
        if (store.valid) begin
            q_addr[wr_ptr] <= store.addr;
            q_data[wr_ptr] <= store.data;
        end
    end

endmodule
